// File: Bender.yml
package:
  name: axi_wrap_ram

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/axi_ram_pkg.sv
      - hdl/axi_stall_gen.sv
      - hdl/axi_burst_ram.sv
      - hdl/axi_wrap_ram.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/axi_wrap_ram_chk.sv
      - tb/tb_axi_wrap_ram.sv

// File: hdl/axi_burst_ram.sv
`include "axi_ram_params.svh"

module axi_burst_ram (
  input  logic                 aclk,
  input  logic                 rst,
  // read address
  input  axi_ram_pkg::axi_ar_t ar,
  input  logic                 ar_valid,
  output logic                 ar_ready,
  // read data
  output axi_ram_pkg::axi_r_t  r,
  output logic                 r_valid,
  input  logic                 r_ready,
  // write address
  input  axi_ram_pkg::axi_ar_t aw,
  input  logic                 aw_valid,
  output logic                 aw_ready,
  // write data
  input  axi_ram_pkg::axi_w_t  w,
  input  logic                 w_valid,
  output logic                 w_ready,
  // write response
  output axi_ram_pkg::axi_b_t  b,
  output logic                 b_valid,
  input  logic                 b_ready
);

  localparam int IDX_W = `AXI_RAM_ADDR_BITS - 2;
  localparam int DEPTH = 1 << IDX_W;

  axi_ram_pkg::axi_data_t  mem [DEPTH];

  axi_ram_pkg::rd_state_t  rd_state;
  axi_ram_pkg::axi_id_t    rd_id;
  axi_ram_pkg::axi_addr_t  rd_addr;
  axi_ram_pkg::axi_addr_t  rd_addr_nxt;
  axi_ram_pkg::axi_len_t   rd_cnt;
  axi_ram_pkg::axi_burst_t rd_burst;
  axi_ram_pkg::axi_data_t  rd_data;
  logic                    ar_xfer;
  logic                    r_xfer;

  axi_ram_pkg::wr_state_t  wr_state;
  axi_ram_pkg::axi_id_t    wr_id;
  axi_ram_pkg::axi_addr_t  wr_addr;
  axi_ram_pkg::axi_len_t   wr_cnt;
  axi_ram_pkg::axi_burst_t wr_burst;
  logic                    aw_xfer;
  logic                    w_xfer;
  logic                    w_done;
  logic                    b_xfer;

  // fixed stays put, incr steps one word, wrap is treated as incr
  function automatic axi_ram_pkg::axi_addr_t next_addr(
    input axi_ram_pkg::axi_addr_t  addr,
    input axi_ram_pkg::axi_burst_t burst
  );
    if (burst == 2'b00)
      return addr;
    return addr + 32'd4;
  endfunction

  function automatic logic [IDX_W-1:0] word_idx(input axi_ram_pkg::axi_addr_t addr);
    return addr[`AXI_RAM_ADDR_BITS-1:2];
  endfunction

  // read side
  assign ar_ready    = (rd_state == axi_ram_pkg::RD_IDLE);
  assign r_valid     = (rd_state == axi_ram_pkg::RD_BURST);
  assign ar_xfer     = ar_valid & ar_ready;
  assign r_xfer      = r_valid & r_ready;
  assign rd_addr_nxt = next_addr(rd_addr, rd_burst);

  assign r.id   = rd_id;
  assign r.data = rd_data;
  assign r.resp = '0;
  assign r.last = (rd_cnt == '0);

  always_ff @(posedge aclk)
  begin
    if (rst)
      rd_state <= axi_ram_pkg::RD_IDLE;
    else
    begin
      case (rd_state)
        axi_ram_pkg::RD_IDLE:
          if (ar_xfer)
            rd_state <= axi_ram_pkg::RD_BURST;
        axi_ram_pkg::RD_BURST:
          if (r_xfer && rd_cnt == '0)
            rd_state <= axi_ram_pkg::RD_IDLE;
        default:
          rd_state <= axi_ram_pkg::RD_IDLE;
      endcase
    end
  end

  // beat data is fetched one cycle ahead so r_valid carries it
  always_ff @(posedge aclk)
  begin
    if (ar_xfer)
    begin
      rd_id    <= ar.id;
      rd_addr  <= ar.addr;
      rd_cnt   <= ar.len;
      rd_burst <= ar.burst;
      rd_data  <= mem[word_idx(ar.addr)];
    end
    else if (r_xfer)
    begin
      rd_addr <= rd_addr_nxt;
      rd_cnt  <= rd_cnt - 1'b1;
      rd_data <= mem[word_idx(rd_addr_nxt)];
    end
  end

  // write side
  assign aw_ready = (wr_state == axi_ram_pkg::WR_IDLE);
  assign w_ready  = (wr_state == axi_ram_pkg::WR_DATA);
  assign b_valid  = (wr_state == axi_ram_pkg::WR_RESP);
  assign aw_xfer  = aw_valid & aw_ready;
  assign w_xfer   = w_valid & w_ready;
  assign b_xfer   = b_valid & b_ready;
  // wlast normally ends the burst, the count is a backstop
  assign w_done   = w_xfer & (w.last | (wr_cnt == '0));

  assign b.id   = wr_id;
  assign b.resp = '0;

  always_ff @(posedge aclk)
  begin
    if (rst)
      wr_state <= axi_ram_pkg::WR_IDLE;
    else
    begin
      case (wr_state)
        axi_ram_pkg::WR_IDLE:
          if (aw_xfer)
            wr_state <= axi_ram_pkg::WR_DATA;
        axi_ram_pkg::WR_DATA:
          if (w_done)
            wr_state <= axi_ram_pkg::WR_RESP;
        axi_ram_pkg::WR_RESP:
          if (b_xfer)
            wr_state <= axi_ram_pkg::WR_IDLE;
        default:
          wr_state <= axi_ram_pkg::WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge aclk)
  begin
    if (aw_xfer)
    begin
      wr_id    <= aw.id;
      wr_addr  <= aw.addr;
      wr_cnt   <= aw.len;
      wr_burst <= aw.burst;
    end
    else if (w_xfer)
    begin
      wr_addr <= next_addr(wr_addr, wr_burst);
      wr_cnt  <= wr_cnt - 1'b1;
    end
  end

  // byte lanes under strobe
  always_ff @(posedge aclk)
  begin
    if (w_xfer)
    begin
      for (int i = 0; i < 4; i++)
      begin
        if (w.strb[i])
          mem[word_idx(wr_addr)][8*i +: 8] <= w.data[8*i +: 8];
      end
    end
  end

endmodule

// File: hdl/axi_ram_params.svh
`ifndef AXI_RAM_PARAMS_SVH
`define AXI_RAM_PARAMS_SVH

// byte address bits decoded by the ram
// 16 bits gives a 64 KB store of 16K words
`define AXI_RAM_ADDR_BITS 16

// perf mode wait from ar transfer to first r beat
`define AXI_RAM_R_DELAY 25

// perf mode wait from aw transfer to b response
`define AXI_RAM_B_DELAY 3

// top address nibbles left untouched by the remap
`define AXI_RAM_SEG_A 4'h0
`define AXI_RAM_SEG_B 4'h1
`define AXI_RAM_SEG_C 4'h7

`endif

// File: hdl/axi_ram_pkg.sv
package axi_ram_pkg;

  // plain field widths
  typedef logic [3:0]  axi_id_t;
  typedef logic [31:0] axi_addr_t;
  typedef logic [31:0] axi_data_t;
  typedef logic [3:0]  axi_strb_t;
  // beats minus one
  typedef logic [3:0]  axi_len_t;
  typedef logic [2:0]  axi_size_t;
  typedef logic [1:0]  axi_burst_t;
  typedef logic [1:0]  axi_resp_t;

  // one enable per channel, msb first ar r aw w b
  typedef logic [4:0]  axi_mask_t;

  // address channel, used for both ar and aw
  typedef struct packed {
    axi_id_t    id;
    axi_addr_t  addr;
    axi_len_t   len;
    axi_size_t  size;
    axi_burst_t burst;
  } axi_ar_t;

  // write data beat
  typedef struct packed {
    axi_data_t data;
    axi_strb_t strb;
    logic      last;
  } axi_w_t;

  // read data beat
  typedef struct packed {
    axi_id_t   id;
    axi_data_t data;
    axi_resp_t resp;
    logic      last;
  } axi_r_t;

  // write response
  typedef struct packed {
    axi_id_t   id;
    axi_resp_t resp;
  } axi_b_t;

  typedef enum logic {RD_IDLE, RD_BURST} rd_state_t;
  typedef enum logic [1:0] {WR_IDLE, WR_DATA, WR_RESP} wr_state_t;

endpackage

// File: hdl/axi_stall_gen.sv
`include "axi_ram_params.svh"

module axi_stall_gen (
  input  logic                   aclk,
  input  logic                   rst,
  input  logic                   perf_mode,
  input  axi_ram_pkg::axi_mask_t ram_random_mask,
  // master side
  input  logic                   ar_valid_m,
  input  logic                   r_ready_m,
  input  logic                   aw_valid_m,
  input  logic                   w_valid_m,
  input  logic                   b_ready_m,
  // ram side
  input  logic                   ar_ready_s,
  input  logic                   r_valid_s,
  input  logic                   aw_ready_s,
  input  logic                   w_ready_s,
  input  logic                   b_valid_s,
  // gated toward the ram
  output logic                   ar_valid_s,
  output logic                   r_ready_s,
  output logic                   aw_valid_s,
  output logic                   w_valid_s,
  output logic                   b_ready_s,
  // gated toward the master
  output logic                   ar_ready_m,
  output logic                   r_valid_m,
  output logic                   aw_ready_m,
  output logic                   w_ready_m,
  output logic                   b_valid_m
);

  localparam int RCNT_W = $clog2(`AXI_RAM_R_DELAY + 1);
  localparam int BCNT_W = $clog2(`AXI_RAM_B_DELAY + 1);

  // sticky flags, set once a valid got through
  logic              ar_seen;
  logic              aw_seen;
  logic              w_seen;
  // perf mode latency counters
  logic [RCNT_W-1:0] r_cnt;
  logic [BCNT_W-1:0] b_cnt;
  logic              ar_en;
  logic              r_en;
  logic              aw_en;
  logic              w_en;
  logic              b_en;
  logic              ar_xfer;
  logic              aw_xfer;
  logic              w_xfer;

  always_comb
  begin
    if (perf_mode)
    begin
      // requests always open, responses wait for their counter
      ar_en = 1'b1;
      r_en  = (r_cnt == '0);
      aw_en = 1'b1;
      w_en  = 1'b1;
      b_en  = (b_cnt == '0);
    end
    else
    begin
      // random mask, but an offered request stays open until taken
      ar_en = ram_random_mask[4] | ar_seen;
      r_en  = ram_random_mask[3];
      aw_en = ram_random_mask[2] | aw_seen;
      w_en  = ram_random_mask[1] | w_seen;
      b_en  = ram_random_mask[0];
    end
  end

  // master to ram
  assign ar_valid_s = ar_valid_m & ar_en;
  assign r_ready_s  = r_ready_m  & r_en;
  assign aw_valid_s = aw_valid_m & aw_en;
  assign w_valid_s  = w_valid_m  & w_en;
  assign b_ready_s  = b_ready_m  & b_en;

  // ram to master
  assign ar_ready_m = ar_ready_s & ar_en;
  assign r_valid_m  = r_valid_s  & r_en;
  assign aw_ready_m = aw_ready_s & aw_en;
  assign w_ready_m  = w_ready_s  & w_en;
  assign b_valid_m  = b_valid_s  & b_en;

  assign ar_xfer = ar_valid_s & ar_ready_s;
  assign aw_xfer = aw_valid_s & aw_ready_s;
  assign w_xfer  = w_valid_s  & w_ready_s;

  always_ff @(posedge aclk)
  begin
    if (rst)
    begin
      ar_seen <= 1'b0;
      aw_seen <= 1'b0;
      w_seen  <= 1'b0;
      r_cnt   <= '0;
      b_cnt   <= '0;
    end
    else
    begin
      // transfer wins over a new offer
      if (ar_xfer)
        ar_seen <= 1'b0;
      else if (ar_valid_s)
        ar_seen <= 1'b1;
      if (aw_xfer)
        aw_seen <= 1'b0;
      else if (aw_valid_s)
        aw_seen <= 1'b1;
      if (w_xfer)
        w_seen <= 1'b0;
      else if (w_valid_s)
        w_seen <= 1'b1;
      // reload on each request, then run down and park at zero
      if (ar_xfer)
        r_cnt <= RCNT_W'(`AXI_RAM_R_DELAY);
      else if (r_cnt != '0)
        r_cnt <= r_cnt - 1'b1;
      if (aw_xfer)
        b_cnt <= BCNT_W'(`AXI_RAM_B_DELAY);
      else if (b_cnt != '0)
        b_cnt <= b_cnt - 1'b1;
    end
  end

endmodule

// File: hdl/axi_wrap_ram.sv
`include "axi_ram_params.svh"

module axi_wrap_ram (
  input  logic                   aclk,
  input  logic                   rst,
  input  logic                   perf_mode,
  input  axi_ram_pkg::axi_mask_t ram_random_mask,
  input  axi_ram_pkg::axi_ar_t   ar,
  input  logic                   ar_valid,
  output logic                   ar_ready,
  output axi_ram_pkg::axi_r_t    r,
  output logic                   r_valid,
  input  logic                   r_ready,
  input  axi_ram_pkg::axi_ar_t   aw,
  input  logic                   aw_valid,
  output logic                   aw_ready,
  input  axi_ram_pkg::axi_w_t    w,
  input  logic                   w_valid,
  output logic                   w_ready,
  output axi_ram_pkg::axi_b_t    b,
  output logic                   b_valid,
  input  logic                   b_ready
);

  axi_ram_pkg::axi_ar_t ram_ar;
  axi_ram_pkg::axi_ar_t ram_aw;
  axi_ram_pkg::axi_r_t  ram_r;
  axi_ram_pkg::axi_b_t  ram_b;
  logic                 ram_ar_valid;
  logic                 ram_ar_ready;
  logic                 ram_r_valid;
  logic                 ram_r_ready;
  logic                 ram_aw_valid;
  logic                 ram_aw_ready;
  logic                 ram_w_valid;
  logic                 ram_w_ready;
  logic                 ram_b_valid;
  logic                 ram_b_ready;

  // segments 0, 1 and 7 pass through
  // everything else folds into 0x000f_s000 by its top nibble
  function automatic axi_ram_pkg::axi_addr_t remap(input axi_ram_pkg::axi_addr_t addr);
    logic [3:0] seg;
    seg = addr[31:28];
    if (seg == `AXI_RAM_SEG_A || seg == `AXI_RAM_SEG_B || seg == `AXI_RAM_SEG_C)
      return addr;
    return {12'h000, 4'hf, seg, addr[11:0]};
  endfunction

  always_comb
  begin
    ram_ar      = ar;
    ram_ar.addr = remap(ar.addr);
    ram_aw      = aw;
    ram_aw.addr = remap(aw.addr);
  end

  // responses read as zero whenever not valid
  assign r = r_valid ? ram_r : '0;
  assign b = b_valid ? ram_b : '0;

  axi_stall_gen u_stall (
    .aclk            (aclk),
    .rst             (rst),
    .perf_mode       (perf_mode),
    .ram_random_mask (ram_random_mask),
    .ar_valid_m      (ar_valid),
    .r_ready_m       (r_ready),
    .aw_valid_m      (aw_valid),
    .w_valid_m       (w_valid),
    .b_ready_m       (b_ready),
    .ar_ready_s      (ram_ar_ready),
    .r_valid_s       (ram_r_valid),
    .aw_ready_s      (ram_aw_ready),
    .w_ready_s       (ram_w_ready),
    .b_valid_s       (ram_b_valid),
    .ar_valid_s      (ram_ar_valid),
    .r_ready_s       (ram_r_ready),
    .aw_valid_s      (ram_aw_valid),
    .w_valid_s       (ram_w_valid),
    .b_ready_s       (ram_b_ready),
    .ar_ready_m      (ar_ready),
    .r_valid_m       (r_valid),
    .aw_ready_m      (aw_ready),
    .w_ready_m       (w_ready),
    .b_valid_m       (b_valid)
  );

  axi_burst_ram u_ram (
    .aclk     (aclk),
    .rst      (rst),
    .ar       (ram_ar),
    .ar_valid (ram_ar_valid),
    .ar_ready (ram_ar_ready),
    .r        (ram_r),
    .r_valid  (ram_r_valid),
    .r_ready  (ram_r_ready),
    .aw       (ram_aw),
    .aw_valid (ram_aw_valid),
    .aw_ready (ram_aw_ready),
    .w        (w),
    .w_valid  (ram_w_valid),
    .w_ready  (ram_w_ready),
    .b        (ram_b),
    .b_valid  (ram_b_valid),
    .b_ready  (ram_b_ready)
  );

endmodule

// File: tb/axi_wrap_ram_chk.sv
module axi_wrap_ram_chk (
  input logic                aclk,
  input logic                rst,
  input logic                perf_mode,
  input axi_ram_pkg::axi_r_t r,
  input logic                r_valid,
  input logic                r_ready,
  input axi_ram_pkg::axi_b_t b,
  input logic                b_valid,
  input logic                b_ready
);

  // failed assertion count, watched by the testbench
  int unsigned err_cnt = 0;

  // idle response channels carry an all-zero payload
  r_zero_idle: assert property (@(posedge aclk) disable iff (rst) !r_valid |-> r == '0)
    else
    begin
      err_cnt++;
      $error("r payload nonzero while r_valid is low");
    end

  b_zero_idle: assert property (@(posedge aclk) disable iff (rst) !b_valid |-> b == '0)
    else
    begin
      err_cnt++;
      $error("b payload nonzero while b_valid is low");
    end

  // fixed latency mode, no response drops before it is taken
  r_hold: assert property (@(posedge aclk) disable iff (rst)
    perf_mode && r_valid && !r_ready |=> r_valid)
    else
    begin
      err_cnt++;
      $error("r_valid dropped before r_ready in performance mode");
    end

  b_hold: assert property (@(posedge aclk) disable iff (rst)
    perf_mode && b_valid && !b_ready |=> b_valid)
    else
    begin
      err_cnt++;
      $error("b_valid dropped before b_ready in performance mode");
    end

endmodule

bind axi_wrap_ram axi_wrap_ram_chk u_chk (
  .aclk      (aclk),
  .rst       (rst),
  .perf_mode (perf_mode),
  .r         (r),
  .r_valid   (r_valid),
  .r_ready   (r_ready),
  .b         (b),
  .b_valid   (b_valid),
  .b_ready   (b_ready)
);

// File: tb/tb_axi_wrap_ram.sv
`include "axi_ram_params.svh"

module tb_axi_wrap_ram;

  localparam int TIMEOUT = 200;

  logic                   aclk;
  logic                   rst;
  logic                   perf_mode;
  axi_ram_pkg::axi_mask_t ram_random_mask;
  axi_ram_pkg::axi_ar_t   ar;
  logic                   ar_valid;
  logic                   ar_ready;
  axi_ram_pkg::axi_r_t    r;
  logic                   r_valid;
  logic                   r_ready;
  axi_ram_pkg::axi_ar_t   aw;
  logic                   aw_valid;
  logic                   aw_ready;
  axi_ram_pkg::axi_w_t    w;
  logic                   w_valid;
  logic                   w_ready;
  axi_ram_pkg::axi_b_t    b;
  logic                   b_valid;
  logic                   b_ready;

  // expected contents, keyed by local word index
  axi_ram_pkg::axi_data_t model [int];
  // edge counter for latency
  int                     cycle = 0;
  int                     lat_r;
  int                     lat_b;
  // random back-pressure on r and b
  logic                   stall_en;

  axi_wrap_ram uut (.*);

  initial
  begin
    aclk = 1'b0;
    forever #2 aclk = ~aclk;
  end

  always @(posedge aclk)
    cycle <= cycle + 1;

  task automatic stop_with_error(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1);
  endtask

  // a failed bound assertion ends the run at the next edge
  always @(posedge aclk)
  begin
    if (uut.u_chk.err_cnt != 0)
      stop_with_error($sformatf("%0d assertion failures seen", uut.u_chk.err_cnt));
  end

  task automatic check_data(input string test, input axi_ram_pkg::axi_data_t exp,
                            input axi_ram_pkg::axi_data_t act);
    if (act !== exp)
      stop_with_error($sformatf("mismatch %s: expected %h actual %h", test, exp, act));
  endtask

  task automatic check_resp(input string test, input axi_ram_pkg::axi_resp_t exp,
                            input axi_ram_pkg::axi_resp_t act);
    if (act !== exp)
      stop_with_error($sformatf("mismatch %s resp: expected %h actual %h", test, exp, act));
  endtask

  task automatic check_id(input string test, input axi_ram_pkg::axi_id_t exp,
                          input axi_ram_pkg::axi_id_t act);
    if (act !== exp)
      stop_with_error($sformatf("mismatch %s id: expected %h actual %h", test, exp, act));
  endtask

  task automatic check_last(input string test, input logic exp, input logic act);
    if (act !== exp)
      stop_with_error($sformatf("mismatch %s last: expected %b actual %b", test, exp, act));
  endtask

  task automatic check_count(input string test, input int exp, input int act);
    if (act != exp)
      stop_with_error($sformatf("mismatch %s: expected %0d actual %0d", test, exp, act));
  endtask

  // to just after the next edge, fresh mask in functional mode
  task automatic tick();
    @(posedge aclk);
    #1;
    if (!perf_mode)
      ram_random_mask = axi_ram_pkg::axi_mask_t'($urandom);
  endtask

  function automatic logic pick_ready();
    if (stall_en)
      return logic'($urandom_range(1, 0));
    return 1'b1;
  endfunction

  // segments 0, 1, 7 as is, others land at 0x000f_s000 plus page offset
  function automatic axi_ram_pkg::axi_addr_t local_addr(input axi_ram_pkg::axi_addr_t addr);
    case (addr[31:28])
      4'h0, 4'h1, 4'h7: return addr;
      default: return 32'h000f_0000 | (32'(addr[31:28]) << 12) | (addr & 32'h0000_0fff);
    endcase
  endfunction

  // fixed bursts stay on one word, incr steps 4 bytes
  function automatic int word_of(input axi_ram_pkg::axi_addr_t addr, input int beat,
                                 input axi_ram_pkg::axi_burst_t burst);
    axi_ram_pkg::axi_addr_t a;
    a = local_addr(addr);
    if (burst != 2'b00)
      a = a + 32'(4 * beat);
    return int'(a[`AXI_RAM_ADDR_BITS-1:2]);
  endfunction

  task automatic axi_write(input string test, input axi_ram_pkg::axi_addr_t addr,
                           input axi_ram_pkg::axi_id_t id, input axi_ram_pkg::axi_burst_t burst,
                           input axi_ram_pkg::axi_data_t data[$],
                           input axi_ram_pkg::axi_strb_t strb[$]);
    int                   n;
    int                   aw_cycle;
    int                   idx;
    axi_ram_pkg::axi_len_t len;
    len = axi_ram_pkg::axi_len_t'(data.size() - 1);
    aw = '{id: id, addr: addr, len: len, size: 3'd2, burst: burst};
    aw_valid = 1'b1;
    n = 0;
    #1;
    while (!aw_ready)
    begin
      n++;
      if (n > TIMEOUT)
        stop_with_error($sformatf("%s: aw not accepted within %0d cycles", test, TIMEOUT));
      tick();
      #1;
    end
    aw_cycle = cycle;
    tick();
    aw_valid = 1'b0;
    for (int i = 0; i <= int'(len); i++)
    begin
      w.data = data[i];
      w.strb = strb[i];
      w.last = (i == int'(len));
      w_valid = 1'b1;
      n = 0;
      #1;
      while (!w_ready)
      begin
        n++;
        if (n > TIMEOUT)
          stop_with_error($sformatf("%s: w beat %0d not accepted in time", test, i));
        tick();
        #1;
      end
      // model takes the bytes under strobe
      idx = word_of(addr, i, burst);
      if (!model.exists(idx))
        model[idx] = 'x;
      for (int k = 0; k < 4; k++)
      begin
        if (strb[i][k])
          model[idx][8*k +: 8] = data[i][8*k +: 8];
      end
      tick();
    end
    w_valid = 1'b0;
    b_ready = pick_ready();
    n = 0;
    #1;
    while (!(b_valid && b_ready))
    begin
      n++;
      if (n > TIMEOUT)
        stop_with_error($sformatf("%s: no write response within %0d cycles", test, TIMEOUT));
      tick();
      b_ready = pick_ready();
      #1;
    end
    check_id(test, id, b.id);
    check_resp(test, 2'b00, b.resp);
    // stalled edges between the aw and b transfers
    lat_b = cycle - aw_cycle - 1;
    tick();
    b_ready = 1'b0;
  endtask

  task automatic axi_read(input string test, input axi_ram_pkg::axi_addr_t addr,
                          input axi_ram_pkg::axi_id_t id, input axi_ram_pkg::axi_len_t len,
                          input axi_ram_pkg::axi_burst_t burst);
    int n;
    int ar_cycle;
    int idx;
    ar = '{id: id, addr: addr, len: len, size: 3'd2, burst: burst};
    ar_valid = 1'b1;
    n = 0;
    #1;
    while (!ar_ready)
    begin
      n++;
      if (n > TIMEOUT)
        stop_with_error($sformatf("%s: ar not accepted within %0d cycles", test, TIMEOUT));
      tick();
      #1;
    end
    ar_cycle = cycle;
    tick();
    ar_valid = 1'b0;
    for (int i = 0; i <= int'(len); i++)
    begin
      r_ready = pick_ready();
      n = 0;
      #1;
      while (!(r_valid && r_ready))
      begin
        n++;
        if (n > TIMEOUT)
          stop_with_error($sformatf("%s: r beat %0d not returned in time", test, i));
        tick();
        r_ready = pick_ready();
        #1;
      end
      if (i == 0)
        lat_r = cycle - ar_cycle - 1;
      idx = word_of(addr, i, burst);
      if (!model.exists(idx))
        stop_with_error($sformatf("%s: read of a word that was never written", test));
      check_data(test, model[idx], r.data);
      check_id(test, id, r.id);
      check_resp(test, 2'b00, r.resp);
      check_last(test, i == int'(len), r.last);
      tick();
    end
    r_ready = 1'b0;
  endtask

  task automatic single_beats();
    axi_ram_pkg::axi_data_t d[$];
    axi_ram_pkg::axi_strb_t s[$];
    perf_mode = 1'b1;
    d = '{32'h1122_3344};
    s = '{4'hf};
    axi_write("single_full", 32'h0000_0040, 4'h3, 2'b01, d, s);
    axi_read("single_full", 32'h0000_0040, 4'h5, 4'd0, 2'b01);
    // bytes 0 and 2 only
    d = '{32'haabb_ccdd};
    s = '{4'b0101};
    axi_write("single_strb", 32'h0000_0040, 4'h6, 2'b01, d, s);
    axi_read("single_strb", 32'h0000_0040, 4'h9, 4'd0, 2'b01);
  endtask

  task automatic incr_and_fixed_bursts();
    axi_ram_pkg::axi_data_t d[$];
    axi_ram_pkg::axi_strb_t s[$];
    // ready stalls while responses wait in performance mode
    stall_en = 1'b1;
    for (int i = 0; i < 16; i++)
    begin
      d.push_back(32'h5a00_0000 + 32'(i) * 32'h0001_0203);
      s.push_back(4'hf);
    end
    axi_write("incr16", 32'h0000_1000, 4'h1, 2'b01, d, s);
    axi_read("incr16", 32'h0000_1000, 4'h2, 4'd15, 2'b01);
    // fixed burst builds one word a lane at a time
    d = '{32'h0000_0011, 32'h0000_2200, 32'h0033_0000, 32'h4400_0000};
    s = '{4'hf, 4'b0010, 4'b0100, 4'b1000};
    axi_write("fixed4", 32'h0000_2000, 4'h4, 2'b00, d, s);
    axi_read("fixed4", 32'h0000_2000, 4'h7, 4'd3, 2'b00);
    stall_en = 1'b0;
  endtask

  task automatic address_remap();
    axi_ram_pkg::axi_data_t d[$];
    axi_ram_pkg::axi_strb_t s[$];
    d = '{32'hcafe_0120};
    s = '{4'hf};
    // segment 8 folds onto 0x000f_8120
    axi_write("remap", 32'h8000_0120, 4'ha, 2'b01, d, s);
    axi_read("remap", 32'h0000_8120, 4'hb, 4'd0, 2'b01);
    d = '{32'h7777_0200};
    axi_write("seg7", 32'h7000_0200, 4'hc, 2'b01, d, s);
    axi_read("seg7", 32'h0000_0200, 4'hd, 4'd0, 2'b01);
  endtask

  task automatic perf_latency();
    axi_ram_pkg::axi_data_t d[$];
    axi_ram_pkg::axi_strb_t s[$];
    perf_mode = 1'b1;
    d = '{32'h0bad_f00d};
    s = '{4'hf};
    axi_write("perf_lat", 32'h0000_0300, 4'h2, 2'b01, d, s);
    check_count("perf_lat_b", `AXI_RAM_B_DELAY, lat_b);
    axi_read("perf_lat", 32'h0000_0300, 4'h3, 4'd0, 2'b01);
    check_count("perf_lat_r", `AXI_RAM_R_DELAY, lat_r);
  endtask

  task automatic random_stalls();
    axi_ram_pkg::axi_data_t  d[$];
    axi_ram_pkg::axi_strb_t  s[$];
    logic [3:0]              segs [5];
    axi_ram_pkg::axi_addr_t  addr;
    axi_ram_pkg::axi_burst_t burst;
    axi_ram_pkg::axi_len_t   len;
    segs = '{4'h0, 4'h1, 4'h7, 4'h8, 4'hc};
    perf_mode = 1'b0;
    stall_en = 1'b1;
    for (int t = 0; t < 12; t++)
    begin
      // 64-byte aligned start keeps 16 beats inside one page
      addr = {segs[$urandom_range(4, 0)], 16'h0000, 6'($urandom), 6'h00};
      burst = ($urandom_range(1, 0) == 0) ? 2'b00 : 2'b01;
      len = axi_ram_pkg::axi_len_t'($urandom_range(15, 0));
      d.delete();
      s.delete();
      for (int i = 0; i <= int'(len); i++)
      begin
        d.push_back($urandom);
        s.push_back(4'hf);
      end
      axi_write("random", addr, axi_ram_pkg::axi_id_t'($urandom), burst, d, s);
      axi_read("random", addr, axi_ram_pkg::axi_id_t'($urandom), len, burst);
    end
    stall_en = 1'b0;
    perf_mode = 1'b1;
  endtask

  initial
  begin
    void'($urandom(10095));
    rst = 1'b1;
    perf_mode = 1'b1;
    ram_random_mask = '1;
    ar = '0;
    ar_valid = 1'b0;
    r_ready = 1'b0;
    aw = '0;
    aw_valid = 1'b0;
    w = '0;
    w_valid = 1'b0;
    b_ready = 1'b0;
    stall_en = 1'b0;
    repeat (8) @(posedge aclk);
    #1;
    rst = 1'b0;
    single_beats();
    incr_and_fixed_bursts();
    address_remap();
    perf_latency();
    random_stalls();
    tick();
    if (uut.u_chk.err_cnt == 0)
    begin
      $display("** PASS **");
      $finish;
    end
    else
      stop_with_error($sformatf("%0d assertion failures seen", uut.u_chk.err_cnt));
  end

endmodule

// File: vlog.f
+incdir+hdl
hdl/axi_ram_pkg.sv
hdl/axi_stall_gen.sv
hdl/axi_burst_ram.sv
hdl/axi_wrap_ram.sv
tb/axi_wrap_ram_chk.sv
tb/tb_axi_wrap_ram.sv
